// File: backend_top.f
source/backend_pkg.sv
source/rename_stage.sv
source/free_list.sv
source/rob.sv
source/int_rs.sv
source/prf.sv
source/backend_top.sv
tests/tb_clock.sv
tests/backend_tb.sv

// File: Makefile
SIM = obj_dir/Vbackend_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the backend testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary -j 0 --top-module backend_tb -Mdir obj_dir -f backend_top.f
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed" && ! echo "$$out" | grep -q "test failed"

clean:
	rm -rf obj_dir

// File: tests/backend_tb.sv
`timescale 1ns/1ps

module backend_tb;

    localparam int TOTAL_INSTR     = 490;
    localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 20 + 200;

    logic                        clk;
    logic                        rst_n;
    logic                        instr_valid_i;
    backend_pkg::instr_t         instr_i;
    logic                        instr_ready_o;
    logic                        commit_valid_o;
    logic [2:0]                  commit_rd_o;
    logic [15:0]                 commit_value_o;

    // architectural model and expected commit stream
    logic [15:0] arf [8];
    logic [2:0]  exp_rd [$];
    logic [15:0] exp_val [$];
    logic [2:0]  pop_rd;
    logic [15:0] pop_val;

    int seed = 32'hca5ec903;
    int errors = 0;
    int ok_cases = 0;
    int bad_cases = 0;
    int accepted_cnt = 0;
    int commit_cnt = 0;
    int stall_cycles = 0;

    tb_clock clock_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    backend_top i_backend_top (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .instr_ready_o  (instr_ready_o),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("ERR %0t: %s got %0h expected %0h", $time, what, actual, expected);
            errors++;
        end
    endtask

    function automatic logic [15:0] alu_model(input backend_pkg::op_e op,
                                              input logic [15:0] a, input logic [15:0] b);
        case (op)
            backend_pkg::OP_ADD: return a + b;
            backend_pkg::OP_SUB: return a - b;
            backend_pkg::OP_AND: return a & b;
            default:             return a ^ b;
        endcase
    endfunction

    // execute in program order at acceptance
    task automatic run_model(input backend_pkg::instr_t ins);
        logic [15:0] b;
        logic [15:0] res;
        if (ins.use_imm) begin
            b = {8'h00, ins.src2.imm};
        end else begin
            b = arf[ins.src2.regs.rs2];
        end
        res = alu_model(ins.op, arf[ins.rs1], b);
        arf[ins.rd] = res;
        exp_rd.push_back(ins.rd);
        exp_val.push_back(res);
        accepted_cnt++;
    endtask

    task automatic make_instr(input logic use_imm, input logic chain,
                              output backend_pkg::instr_t ins);
        logic [31:0] r;
        r = $random(seed);
        ins = '0;
        ins.op = backend_pkg::op_e'(r[1:0]);
        ins.use_imm = use_imm;
        ins.rd = chain ? 3'd1 : r[4:2];
        ins.rs1 = chain ? 3'd1 : r[7:5];
        if (use_imm) begin
            ins.src2.imm = r[15:8];
        end else begin
            ins.src2.regs.rs2 = chain ? 3'd1 : r[10:8];
        end
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic send(input backend_pkg::instr_t ins);
        instr_i = ins;
        instr_valid_i = 1'b1;
        @(negedge clk);
        while (!instr_ready_o) begin
            stall_cycles++;
            @(negedge clk);
        end
        run_model(ins);
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
    endtask

    // wait for outstanding commits, bounded by the per-instruction latency
    task automatic drain();
        int budget;
        budget = exp_rd.size() * 20 + 50;
        while (exp_rd.size() != 0 && budget > 0) begin
            @(negedge clk);
            budget--;
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_case(input string name, input int start_errors);
        if (errors == start_errors) begin
            ok_cases++;
            $display("case %s: ok", name);
        end else begin
            bad_cases++;
            $display("case %s: FAIL with %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic send_random(input int count, input int mode, input logic gaps);
        backend_pkg::instr_t ins;
        logic [31:0] r;
        for (int n = 0; n < count; n++) begin
            r = $random(seed);
            if (gaps) begin
                repeat (int'(r[1:0])) begin
                    @(posedge clk);
                    #1;
                end
            end
            // mode 0 reg-reg, 1 immediate, 2 mixed
            make_instr(mode == 2 ? r[2] : mode == 1, 1'b0, ins);
            send(ins);
        end
    endtask

    // commit monitor, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && commit_valid_o) begin
            commit_cnt++;
            if (exp_rd.size() == 0) begin
                $display("commit of register %0d at %0t with nothing outstanding",
                         commit_rd_o, $time);
                errors++;
            end else begin
                pop_rd = exp_rd.pop_front();
                pop_val = exp_val.pop_front();
                check(32'(commit_rd_o), 32'(pop_rd), "commit rd");
                check(32'(commit_value_o), 32'(pop_val), "commit value");
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("run timed out after %0d cycles, %0d commits still outstanding",
                 WATCHDOG_CYCLES, exp_rd.size());
        $display("test failed");
        $finish;
    end

    initial begin
        int start;
        int acc_start;
        int com_start;
        int stall_start;
        backend_pkg::instr_t ins;
        instr_valid_i = 1'b0;
        instr_i = '0;
        for (int i = 0; i < 8; i++) begin
            arf[i] = '0;
        end
        @(posedge rst_n);
        @(posedge clk);
        #1;

        start = errors;
        repeat (5) begin
            @(negedge clk);
            check(32'(instr_ready_o), 32'd1, "ready after reset");
            check(32'(commit_valid_o), 32'd0, "commit after reset");
        end
        @(posedge clk);
        #1;
        report_case("idle after reset", start);

        // immediates first so the registers hold non-zero data
        start = errors;
        send_random(100, 1, 1'b0);
        drain();
        report_case("immediate", start);

        start = errors;
        send_random(200, 0, 1'b0);
        drain();
        report_case("reg-reg", start);

        start = errors;
        acc_start = accepted_cnt;
        com_start = commit_cnt;
        stall_start = stall_cycles;
        for (int n = 0; n < 40; n++) begin
            make_instr(1'($random(seed)), 1'b1, ins);
            send(ins);
        end
        drain();
        check(32'(stall_cycles > stall_start), 32'd1, "ready dropped in chain burst");
        check(commit_cnt - com_start, accepted_cnt - acc_start, "chain commit count");
        report_case("dependency chain", start);

        start = errors;
        send_random(150, 2, 1'b1);
        drain();
        check(exp_rd.size(), 32'd0, "model queue left over");
        report_case("mixed with gaps", start);

        $display("cases: %0d ok, %0d failing, %0d errors, %0d commits",
                 ok_cases, bad_cases, errors, commit_cnt);
        if (errors == 0 && bad_cases == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk_o,
    output logic rst_n_o
);

    // 100 ns period
    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // reset held low for four rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #1 rst_n_o = 1'b1;
    end

endmodule

// File: source/backend_top.sv
`timescale 1ns/1ps

module backend_top (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            instr_valid_i,
    input  backend_pkg::instr_t             instr_i,
    output logic                            instr_ready_o,

    output logic                            commit_valid_o,
    output logic [backend_pkg::ARF_IDX-1:0] commit_rd_o,
    output logic [backend_pkg::XLEN-1:0]    commit_value_o
);

    logic                            dispatch;
    backend_pkg::op_e                ds_op;
    logic                            ds_use_imm;
    logic [7:0]                      ds_imm;
    logic [backend_pkg::PRF_IDX-1:0] ds_prs1;
    logic [backend_pkg::PRF_IDX-1:0] ds_prs2;
    logic [backend_pkg::PRF_IDX-1:0] ds_prd;
    logic [backend_pkg::PRF_IDX-1:0] ds_old_prd;
    logic [backend_pkg::ARF_IDX-1:0] ds_ard;

    logic                            free_empty;
    logic [backend_pkg::PRF_IDX-1:0] free_head;
    logic                            free_push;
    logic [backend_pkg::PRF_IDX-1:0] free_tag;

    logic                            rob_full;
    logic [backend_pkg::ROB_IDX-1:0] rob_tail;
    logic                            rs_full;
    logic                            src1_ready;
    logic                            src2_ready;
    logic [backend_pkg::PRF_IDX-1:0] rs1_tag;
    logic [backend_pkg::PRF_IDX-1:0] rs2_tag;
    logic [backend_pkg::XLEN-1:0]    rs1_value;
    logic [backend_pkg::XLEN-1:0]    rs2_value;

    // common data bus
    logic                            cdb_valid;
    logic [backend_pkg::PRF_IDX-1:0] cdb_tag;
    logic [backend_pkg::XLEN-1:0]    cdb_value;
    logic [backend_pkg::ROB_IDX-1:0] cdb_rob_idx;

    rename_stage rename_stage_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .free_empty_i   (free_empty),
        .free_head_i    (free_head),
        .rob_full_i     (rob_full),
        .rs_full_i      (rs_full),
        .instr_ready_o  (instr_ready_o),
        .dispatch_o     (dispatch),
        .op_o           (ds_op),
        .use_imm_o      (ds_use_imm),
        .imm_o          (ds_imm),
        .prs1_o         (ds_prs1),
        .prs2_o         (ds_prs2),
        .prd_o          (ds_prd),
        .old_prd_o      (ds_old_prd),
        .ard_o          (ds_ard)
    );

    free_list free_list_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .pop_i          (dispatch),
        .push_i         (free_push),
        .push_tag_i     (free_tag),
        .empty_o        (free_empty),
        .head_o         (free_head)
    );

    rob rob_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .dispatch_i     (dispatch),
        .ard_i          (ds_ard),
        .prd_i          (ds_prd),
        .old_prd_i      (ds_old_prd),
        .cdb_valid_i    (cdb_valid),
        .cdb_tag_i      (cdb_tag),
        .cdb_rob_idx_i  (cdb_rob_idx),
        .cdb_value_i    (cdb_value),
        .full_o         (rob_full),
        .tail_o         (rob_tail),
        .free_push_o    (free_push),
        .free_tag_o     (free_tag),
        .commit_valid_o (commit_valid_o),
        .commit_rd_o    (commit_rd_o),
        .commit_value_o (commit_value_o)
    );

    int_rs int_rs_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .dispatch_i     (dispatch),
        .op_i           (ds_op),
        .use_imm_i      (ds_use_imm),
        .imm_i          (ds_imm),
        .prs1_i         (ds_prs1),
        .prs2_i         (ds_prs2),
        .prd_i          (ds_prd),
        .rob_idx_i      (rob_tail),
        .src1_ready_i   (src1_ready),
        .src2_ready_i   (src2_ready),
        .rs1_value_i    (rs1_value),
        .rs2_value_i    (rs2_value),
        .rs1_tag_o      (rs1_tag),
        .rs2_tag_o      (rs2_tag),
        .full_o         (rs_full),
        .cdb_valid_o    (cdb_valid),
        .cdb_tag_o      (cdb_tag),
        .cdb_value_o    (cdb_value),
        .cdb_rob_idx_o  (cdb_rob_idx)
    );

    prf prf_i (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .alloc_i        (dispatch),
        .alloc_tag_i    (ds_prd),
        .rd1_tag_i      (rs1_tag),
        .rd2_tag_i      (rs2_tag),
        .rd1_o          (rs1_value),
        .rd2_o          (rs2_value),
        .chk1_tag_i     (ds_prs1),
        .chk2_tag_i     (ds_prs2),
        .rdy1_o         (src1_ready),
        .rdy2_o         (src2_ready),
        .cdb_valid_i    (cdb_valid),
        .cdb_tag_i      (cdb_tag),
        .cdb_value_i    (cdb_value)
    );

endmodule

// File: source/prf.sv
`timescale 1ns/1ps

module prf (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            alloc_i,
    input  logic [backend_pkg::PRF_IDX-1:0] alloc_tag_i,

    input  logic [backend_pkg::PRF_IDX-1:0] rd1_tag_i,
    input  logic [backend_pkg::PRF_IDX-1:0] rd2_tag_i,
    output logic [backend_pkg::XLEN-1:0]    rd1_o,
    output logic [backend_pkg::XLEN-1:0]    rd2_o,

    input  logic [backend_pkg::PRF_IDX-1:0] chk1_tag_i,
    input  logic [backend_pkg::PRF_IDX-1:0] chk2_tag_i,
    output logic                            rdy1_o,
    output logic                            rdy2_o,

    input  logic                            cdb_valid_i,
    input  logic [backend_pkg::PRF_IDX-1:0] cdb_tag_i,
    input  logic [backend_pkg::XLEN-1:0]    cdb_value_i
);

    logic [backend_pkg::XLEN-1:0]      value_q [backend_pkg::PRF_DEPTH];
    logic [backend_pkg::PRF_DEPTH-1:0] ready_q;

    assign rd1_o  = value_q[rd1_tag_i];
    assign rd2_o  = value_q[rd2_tag_i];
    assign rdy1_o = ready_q[chk1_tag_i];
    assign rdy2_o = ready_q[chk2_tag_i];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            ready_q <= '1;
            for (int i = 0; i < backend_pkg::PRF_DEPTH; i++) begin
                value_q[i] <= '0;
            end
        end else begin
            // new destination waits for its result
            if (alloc_i) begin
                ready_q[alloc_tag_i] <= 1'b0;
            end
            if (cdb_valid_i) begin
                ready_q[cdb_tag_i] <= 1'b1;
                value_q[cdb_tag_i] <= cdb_value_i;
            end
        end
    end

endmodule

// File: source/int_rs.sv
`timescale 1ns/1ps

module int_rs (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            dispatch_i,
    input  backend_pkg::op_e                op_i,
    input  logic                            use_imm_i,
    input  logic [7:0]                      imm_i,
    input  logic [backend_pkg::PRF_IDX-1:0] prs1_i,
    input  logic [backend_pkg::PRF_IDX-1:0] prs2_i,
    input  logic [backend_pkg::PRF_IDX-1:0] prd_i,
    input  logic [backend_pkg::ROB_IDX-1:0] rob_idx_i,
    input  logic                            src1_ready_i,
    input  logic                            src2_ready_i,

    input  logic [backend_pkg::XLEN-1:0]    rs1_value_i,
    input  logic [backend_pkg::XLEN-1:0]    rs2_value_i,
    output logic [backend_pkg::PRF_IDX-1:0] rs1_tag_o,
    output logic [backend_pkg::PRF_IDX-1:0] rs2_tag_o,

    output logic                            full_o,

    output logic                            cdb_valid_o,
    output logic [backend_pkg::PRF_IDX-1:0] cdb_tag_o,
    output logic [backend_pkg::XLEN-1:0]    cdb_value_o,
    output logic [backend_pkg::ROB_IDX-1:0] cdb_rob_idx_o
);

    logic [backend_pkg::RS_DEPTH-1:0] valid_q;
    logic [backend_pkg::RS_DEPTH-1:0] rdy1_q;
    logic [backend_pkg::RS_DEPTH-1:0] rdy2_q;
    backend_pkg::op_e                 op_q      [backend_pkg::RS_DEPTH];
    logic                             use_imm_q [backend_pkg::RS_DEPTH];
    logic [7:0]                       imm_q     [backend_pkg::RS_DEPTH];
    logic [backend_pkg::PRF_IDX-1:0]  tag1_q    [backend_pkg::RS_DEPTH];
    logic [backend_pkg::PRF_IDX-1:0]  tag2_q    [backend_pkg::RS_DEPTH];
    logic [backend_pkg::PRF_IDX-1:0]  prd_q     [backend_pkg::RS_DEPTH];
    logic [backend_pkg::ROB_IDX-1:0]  rob_q     [backend_pkg::RS_DEPTH];
    // older_q[i][j] set when entry i was dispatched before entry j
    logic [backend_pkg::RS_DEPTH-1:0] older_q   [backend_pkg::RS_DEPTH];

    logic [backend_pkg::RS_DEPTH-1:0] req;
    logic                             blocked;
    logic                             issue_vld;
    logic [backend_pkg::RS_IDX-1:0]   issue_idx;
    logic [backend_pkg::RS_IDX-1:0]   alloc_idx;
    logic [backend_pkg::XLEN-1:0]     opb;
    logic [backend_pkg::XLEN-1:0]     alu_res;

    assign full_o = &valid_q;

    // lowest free slot
    always_comb begin
        alloc_idx = '0;
        for (int i = backend_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                alloc_idx = backend_pkg::RS_IDX'(i);
            end
        end
    end

    // oldest entry with both operands ready
    always_comb begin
        req       = valid_q & rdy1_q & rdy2_q;
        issue_vld = 1'b0;
        issue_idx = '0;
        blocked   = 1'b0;
        for (int i = 0; i < backend_pkg::RS_DEPTH; i++) begin
            blocked = 1'b0;
            for (int j = 0; j < backend_pkg::RS_DEPTH; j++) begin
                if (req[j] && older_q[j][i]) begin
                    blocked = 1'b1;
                end
            end
            if (req[i] && !blocked) begin
                issue_vld = 1'b1;
                issue_idx = backend_pkg::RS_IDX'(i);
            end
        end
    end

    assign rs1_tag_o = tag1_q[issue_idx];
    assign rs2_tag_o = tag2_q[issue_idx];

    // ALU
    assign opb = use_imm_q[issue_idx] ? {{(backend_pkg::XLEN - 8){1'b0}}, imm_q[issue_idx]}
                                      : rs2_value_i;

    always_comb begin
        case (op_q[issue_idx])
            backend_pkg::OP_ADD: alu_res = rs1_value_i + opb;
            backend_pkg::OP_SUB: alu_res = rs1_value_i - opb;
            backend_pkg::OP_AND: alu_res = rs1_value_i & opb;
            default:             alu_res = rs1_value_i ^ opb;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q     <= '0;
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= issue_vld;
            if (issue_vld) begin
                valid_q[issue_idx] <= 1'b0;
            end
            if (dispatch_i) begin
                valid_q[alloc_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // wake-up from the bus
        for (int i = 0; i < backend_pkg::RS_DEPTH; i++) begin
            if (cdb_valid_o && tag1_q[i] == cdb_tag_o) begin
                rdy1_q[i] <= 1'b1;
            end
            if (cdb_valid_o && tag2_q[i] == cdb_tag_o) begin
                rdy2_q[i] <= 1'b1;
            end
        end
        if (dispatch_i) begin
            op_q[alloc_idx]      <= op_i;
            use_imm_q[alloc_idx] <= use_imm_i;
            imm_q[alloc_idx]     <= imm_i;
            tag1_q[alloc_idx]    <= prs1_i;
            tag2_q[alloc_idx]    <= prs2_i;
            prd_q[alloc_idx]     <= prd_i;
            rob_q[alloc_idx]     <= rob_idx_i;
            // bus result in this very cycle counts too
            rdy1_q[alloc_idx]    <= src1_ready_i || (cdb_valid_o && cdb_tag_o == prs1_i);
            rdy2_q[alloc_idx]    <= use_imm_i || src2_ready_i
                                    || (cdb_valid_o && cdb_tag_o == prs2_i);
            older_q[alloc_idx]   <= '0;
            for (int j = 0; j < backend_pkg::RS_DEPTH; j++) begin
                older_q[j][alloc_idx] <= valid_q[j];
            end
        end
        // result stage
        cdb_tag_o     <= prd_q[issue_idx];
        cdb_value_o   <= alu_res;
        cdb_rob_idx_o <= rob_q[issue_idx];
    end

endmodule

// File: source/rob.sv
`timescale 1ns/1ps

module rob (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            dispatch_i,
    input  logic [backend_pkg::ARF_IDX-1:0] ard_i,
    input  logic [backend_pkg::PRF_IDX-1:0] prd_i,
    input  logic [backend_pkg::PRF_IDX-1:0] old_prd_i,

    input  logic                            cdb_valid_i,
    input  logic [backend_pkg::PRF_IDX-1:0] cdb_tag_i,
    input  logic [backend_pkg::ROB_IDX-1:0] cdb_rob_idx_i,
    input  logic [backend_pkg::XLEN-1:0]    cdb_value_i,

    output logic                            full_o,
    output logic [backend_pkg::ROB_IDX-1:0] tail_o,

    output logic                            free_push_o,
    output logic [backend_pkg::PRF_IDX-1:0] free_tag_o,

    output logic                            commit_valid_o,
    output logic [backend_pkg::ARF_IDX-1:0] commit_rd_o,
    output logic [backend_pkg::XLEN-1:0]    commit_value_o
);

    logic [backend_pkg::ARF_IDX-1:0] ard_q     [backend_pkg::ROB_DEPTH];
    logic [backend_pkg::PRF_IDX-1:0] prd_q     [backend_pkg::ROB_DEPTH];
    logic [backend_pkg::PRF_IDX-1:0] old_prd_q [backend_pkg::ROB_DEPTH];
    logic [backend_pkg::XLEN-1:0]    value_q   [backend_pkg::ROB_DEPTH];
    logic [backend_pkg::ROB_DEPTH-1:0] done_q;

    logic [backend_pkg::ROB_IDX-1:0] head_q;
    logic [backend_pkg::ROB_IDX-1:0] tail_q;
    logic [backend_pkg::ROB_IDX:0]   count_q;

    assign full_o = (count_q == (backend_pkg::ROB_IDX + 1)'(backend_pkg::ROB_DEPTH));
    assign tail_o = tail_q;

    // retire the head once its result is back
    assign commit_valid_o = (count_q != '0) && done_q[head_q];
    assign commit_rd_o    = ard_q[head_q];
    assign commit_value_o = value_q[head_q];

    // the previous mapping is dead after retirement
    assign free_push_o = commit_valid_o;
    assign free_tag_o  = old_prd_q[head_q];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (dispatch_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (cdb_valid_i && prd_q[cdb_rob_idx_i] == cdb_tag_i) begin
                done_q[cdb_rob_idx_i] <= 1'b1;
            end
            if (commit_valid_o) begin
                head_q <= head_q + 1'b1;
            end
            if (dispatch_i && !commit_valid_o) begin
                count_q <= count_q + 1'b1;
            end else if (commit_valid_o && !dispatch_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (dispatch_i) begin
            ard_q[tail_q]     <= ard_i;
            prd_q[tail_q]     <= prd_i;
            old_prd_q[tail_q] <= old_prd_i;
        end
        if (cdb_valid_i) begin
            value_q[cdb_rob_idx_i] <= cdb_value_i;
        end
    end

endmodule

// File: source/free_list.sv
`timescale 1ns/1ps

module free_list (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            pop_i,
    input  logic                            push_i,
    input  logic [backend_pkg::PRF_IDX-1:0] push_tag_i,

    output logic                            empty_o,
    output logic [backend_pkg::PRF_IDX-1:0] head_o
);

    logic [backend_pkg::PRF_IDX-1:0] slot_q [backend_pkg::PRF_DEPTH];
    logic [backend_pkg::PRF_IDX-1:0] head_q;
    logic [backend_pkg::PRF_IDX-1:0] tail_q;
    logic [backend_pkg::PRF_IDX:0]   count_q;

    assign empty_o = (count_q == '0);
    assign head_o  = slot_q[head_q];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            // tags above the arch range start out free
            for (int i = 0; i < backend_pkg::ARF_DEPTH; i++) begin
                slot_q[i] <= backend_pkg::PRF_IDX'(i + backend_pkg::ARF_DEPTH);
            end
            head_q  <= '0;
            tail_q  <= backend_pkg::PRF_IDX'(backend_pkg::ARF_DEPTH);
            count_q <= (backend_pkg::PRF_IDX + 1)'(backend_pkg::PRF_DEPTH - backend_pkg::ARF_DEPTH);
        end else begin
            if (pop_i) begin
                head_q <= head_q + 1'b1;
            end
            if (push_i) begin
                slot_q[tail_q] <= push_tag_i;
                tail_q         <= tail_q + 1'b1;
            end
            // pop and push together leave the count alone
            if (pop_i && !push_i) begin
                count_q <= count_q - 1'b1;
            end else if (push_i && !pop_i) begin
                count_q <= count_q + 1'b1;
            end
        end
    end

endmodule

// File: source/rename_stage.sv
`timescale 1ns/1ps

module rename_stage (
    input  logic                            clk,
    input  logic                            rst_n_i,

    input  logic                            instr_valid_i,
    input  backend_pkg::instr_t             instr_i,

    input  logic                            free_empty_i,
    input  logic [backend_pkg::PRF_IDX-1:0] free_head_i,
    input  logic                            rob_full_i,
    input  logic                            rs_full_i,

    output logic                            instr_ready_o,
    output logic                            dispatch_o,

    output backend_pkg::op_e                op_o,
    output logic                            use_imm_o,
    output logic [7:0]                      imm_o,
    output logic [backend_pkg::PRF_IDX-1:0] prs1_o,
    output logic [backend_pkg::PRF_IDX-1:0] prs2_o,
    output logic [backend_pkg::PRF_IDX-1:0] prd_o,
    output logic [backend_pkg::PRF_IDX-1:0] old_prd_o,
    output logic [backend_pkg::ARF_IDX-1:0] ard_o
);

    // arch to phys alias table
    logic [backend_pkg::PRF_IDX-1:0] rat_q [backend_pkg::ARF_DEPTH];

    // stall while any downstream block is out of room
    assign instr_ready_o = !free_empty_i && !rob_full_i && !rs_full_i;
    assign dispatch_o    = instr_valid_i && instr_ready_o;

    assign op_o      = instr_i.op;
    assign use_imm_o = instr_i.use_imm;
    assign imm_o     = instr_i.src2.imm;
    assign ard_o     = instr_i.rd;

    // sources see the mapping from before this instruction
    assign prs1_o    = rat_q[instr_i.rs1];
    assign prs2_o    = rat_q[instr_i.src2.regs.rs2];
    assign prd_o     = free_head_i;
    assign old_prd_o = rat_q[instr_i.rd];

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            // identity mapping
            for (int i = 0; i < backend_pkg::ARF_DEPTH; i++) begin
                rat_q[i] <= backend_pkg::PRF_IDX'(i);
            end
        end else if (dispatch_o) begin
            rat_q[instr_i.rd] <= free_head_i;
        end
    end

endmodule

// File: source/backend_pkg.sv
package backend_pkg;

    // datapath and register file sizes
    localparam int XLEN      = 16;
    localparam int ARF_DEPTH = 8;
    localparam int ARF_IDX   = 3;
    localparam int PRF_DEPTH = 16;
    localparam int PRF_IDX   = 4;

    // window sizes
    localparam int ROB_DEPTH = 8;
    localparam int ROB_IDX   = 3;
    localparam int RS_DEPTH  = 4;
    localparam int RS_IDX    = 2;

    typedef enum logic [1:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_XOR
    } op_e;

    // second operand field, immediate or register view
    typedef union packed {
        logic [7:0] imm;
        struct packed {
            logic [4:0] pad;
            logic [2:0] rs2;
        } regs;
    } src2_u;

    typedef struct packed {
        op_e        op;
        logic       use_imm;
        logic [2:0] rd;
        logic [2:0] rs1;
        logic       pad;
        src2_u      src2;
    } instr_t;

endpackage
